/* ethernet_rx.f */
logic/eth_mii_pkg.sv
logic/eth_frame_pkg.sv
logic/nibble_assembler.sv
logic/frame_rx_ctrl.sv
logic/header_capture.sv
logic/payload_output.sv
logic/ethernet_rx.sv
sim/ethernet_rx_tb.sv

/* sim/ethernet_rx_tb.sv */
`default_nettype none

module ethernet_rx_tb
    import eth_mii_pkg::*, eth_frame_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Longest frame of 60 bytes plus the waits after it
    localparam int FRAME_CYCLES   = 2 * (8 + 12 + 40) + 24;
    // Eleven frames in all
    localparam int TIMEOUT_CYCLES = 10 * 11 * FRAME_CYCLES;

    logic        phy_rx_clk;
    logic        reset;
    logic [3:0]  phy_rxd;
    logic        phy_rx_ctrl;
    logic [7:0]  rx_data_out;
    logic        data_out_valid;
    logic        frame_done;
    frame_info_t frame_info;
    rx_state_e   status;

    logic [7:0]  got_bytes[$];
    logic [7:0]  exp_bytes[$];
    frame_info_t got_infos[$];
    frame_info_t exp_infos[$];
    logic [7:0]  payload[$];
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    ethernet_rx i_ethernet_rx (
        .phy_rx_clk     (phy_rx_clk),
        .reset          (reset),
        .phy_rxd        (phy_rxd),
        .phy_rx_ctrl    (phy_rx_ctrl),
        .rx_data_out    (rx_data_out),
        .data_out_valid (data_out_valid),
        .frame_done     (frame_done),
        .frame_info     (frame_info),
        .status         (status)
    );

    initial
    begin
        phy_rx_clk = 1'b0;
        forever #10 phy_rx_clk = ~phy_rx_clk;
    end

    // Output monitor
    always @(posedge phy_rx_clk)
    begin
        if (data_out_valid === 1'b1)
            got_bytes.push_back(rx_data_out);
        if (frame_done === 1'b1)
            got_infos.push_back(frame_info);
    end

    initial
    begin
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge phy_rx_clk);
            cycle_count++;
        end
        $display("Run stopped by timeout after %0d cycles", cycle_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Fail at %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_info(input frame_info_t got, input frame_info_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Fail at %0t: summary src %h len %0d match %b, expected %h %0d %b",
                     $time, got.src_mac, got.payload_len, got.addr_match,
                     exp.src_mac, exp.payload_len, exp.addr_match);
        end
    endtask

    task automatic check_state(input rx_state_e got, input rx_state_e exp, input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge phy_rx_clk);
    endtask

    task automatic fill_payload(input int len);
        payload.delete();
        for (int i = 0; i < len; i++)
            payload.push_back(8'($urandom));
    endtask

    // A negative abort_at sends the whole frame
    task automatic send_frame(input int pre_len, input logic [7:0] sfd, input mac_addr_t dest,
                              input mac_addr_t src, input logic [7:0] data[$],
                              input int abort_at);
        logic [7:0]  frame[$];
        frame_info_t info;
        int          limit;
        for (int i = 0; i < pre_len; i++)
            frame.push_back(PREAMBLE_BYTE);
        frame.push_back(sfd);
        for (int i = 0; i < 6; i++)
            frame.push_back(dest[47 - 8 * i -: 8]);
        for (int i = 0; i < 6; i++)
            frame.push_back(src[47 - 8 * i -: 8]);
        for (int i = 0; i < data.size(); i++)
            frame.push_back(data[i]);
        limit = (abort_at >= 0) ? abort_at : frame.size();
        for (int i = 0; i < limit; i++)
        begin
            @(posedge phy_rx_clk);
            phy_rx_ctrl <= 1'b1;
            phy_rxd     <= frame[i][3:0];
            @(posedge phy_rx_clk);
            phy_rxd     <= frame[i][7:4];
        end
        @(posedge phy_rx_clk);
        phy_rx_ctrl <= 1'b0;
        phy_rxd     <= 4'd0;
        // Only a clean 7 x 0x55 + 0xD5 frame without abort is summarized
        if (pre_len == 7 && sfd == 8'hD5 && abort_at < 0)
        begin
            info = '{src_mac: src, payload_len: payload_len_t'(data.size()),
                     addr_match: (dest == 48'h30_9C_23_1E_EC_21)};
            exp_infos.push_back(info);
            if (info.addr_match)
                for (int i = 0; i < data.size(); i++)
                    exp_bytes.push_back(data[i]);
        end
    endtask

    task automatic compare_results();
        int waited;
        waited = 0;
        while (got_infos.size() < exp_infos.size() && waited < 8)
        begin
            @(posedge phy_rx_clk);
            waited++;
        end
        if (got_infos.size() < exp_infos.size())
        begin
            error_count++;
            $display("No frame_done within 8 cycles after the end of a frame at %0t", $time);
        end
        // Room for stray strobes
        idle_cycles(4);
        if (got_bytes.size() != exp_bytes.size() || got_infos.size() != exp_infos.size())
        begin
            error_count++;
            $display("Received %0d bytes and %0d summaries where %0d and %0d were expected",
                     got_bytes.size(), got_infos.size(), exp_bytes.size(), exp_infos.size());
        end
        for (int i = 0; i < got_bytes.size() && i < exp_bytes.size(); i++)
            check_byte(got_bytes[i], exp_bytes[i], "payload byte");
        for (int i = 0; i < got_infos.size() && i < exp_infos.size(); i++)
            check_info(got_infos[i], exp_infos[i]);
        got_bytes.delete();
        exp_bytes.delete();
        got_infos.delete();
        exp_infos.delete();
    endtask

    task automatic wait_idle_state(input string what);
        idle_cycles(3);
        @(negedge phy_rx_clk);
        check_state(status, IDLE, what);
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_reset();
        @(negedge phy_rx_clk);
        check_state(status, IDLE, "status after reset");
        check_flag(data_out_valid, 1'b0, "data_out_valid after reset");
        check_flag(frame_done, 1'b0, "frame_done after reset");
    endtask

    task automatic test_matched();
        fill_payload(1 + $urandom % 40);
        send_frame(7, SFD_BYTE, BOARD_MAC, 48'h02_11_22_33_44_01, payload, -1);
        compare_results();
    endtask

    task automatic test_unmatched();
        fill_payload(1 + $urandom % 40);
        send_frame(7, SFD_BYTE, 48'h02_AA_BB_CC_DD_EE, 48'h02_11_22_33_44_02, payload, -1);
        compare_results();
    endtask

    task automatic test_bad_framing();
        fill_payload(1 + $urandom % 40);
        send_frame(6, SFD_BYTE, BOARD_MAC, 48'h02_11_22_33_44_03, payload, -1);
        wait_idle_state("status after short preamble");
        send_frame(7, 8'hD4, BOARD_MAC, 48'h02_11_22_33_44_04, payload, -1);
        wait_idle_state("status after wrong delimiter");
        fill_payload(1 + $urandom % 40);
        send_frame(7, SFD_BYTE, BOARD_MAC, 48'h02_11_22_33_44_05, payload, -1);
        compare_results();
    endtask

    task automatic test_aborted_header();
        fill_payload(1 + $urandom % 40);
        // Drop after the third source byte
        send_frame(7, SFD_BYTE, BOARD_MAC, 48'h02_11_22_33_44_06, payload, 17);
        wait_idle_state("status after aborted header");
        fill_payload(1 + $urandom % 40);
        send_frame(7, SFD_BYTE, BOARD_MAC, 48'h02_11_22_33_44_07, payload, -1);
        compare_results();
    endtask

    task automatic test_back_to_back();
        for (int i = 0; i < 4; i++)
        begin
            fill_payload(1 + $urandom % 40);
            send_frame(7, SFD_BYTE, BOARD_MAC, 48'h02_00_00_00_00_10 + i, payload, -1);
            // Two idle cycles in all
            idle_cycles(1);
        end
        compare_results();
    endtask

    initial
    begin
        int seed_val;
        seed_val    = $urandom(2205);
        reset       = 1'b1;
        phy_rxd     = 4'd0;
        phy_rx_ctrl = 1'b0;
        repeat (4) @(posedge phy_rx_clk);
        reset <= 1'b0;
        test_reset();
        test_matched();
        test_unmatched();
        test_bad_framing();
        test_aborted_header();
        test_back_to_back();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/ethernet_rx.sv */
`default_nettype none

module ethernet_rx
    import eth_mii_pkg::*, eth_frame_pkg::*;
(
    input  wire logic       phy_rx_clk,
    input  wire logic       reset,
    input  wire logic [3:0] phy_rxd,
    input  wire logic       phy_rx_ctrl,
    output logic [7:0]      rx_data_out,
    output logic            data_out_valid,
    output logic            frame_done,
    output frame_info_t     frame_info,
    output rx_state_e       status
);

    rx_byte_t  rx_byte;
    rx_ctrl_t  ctrl;
    mac_addr_t src_mac;
    logic      addr_match;

    nibble_assembler i_nibble_assembler (
        .phy_rx_clk  (phy_rx_clk),
        .reset       (reset),
        .phy_rxd     (phy_rxd),
        .phy_rx_ctrl (phy_rx_ctrl),
        .rx_byte     (rx_byte)
    );

    frame_rx_ctrl i_frame_rx_ctrl (
        .phy_rx_clk (phy_rx_clk),
        .reset      (reset),
        .rx_byte    (rx_byte),
        .ctrl       (ctrl),
        .status     (status)
    );

    header_capture i_header_capture (
        .phy_rx_clk (phy_rx_clk),
        .reset      (reset),
        .rx_byte    (rx_byte),
        .ctrl       (ctrl),
        .src_mac    (src_mac),
        .addr_match (addr_match)
    );

    payload_output i_payload_output (
        .phy_rx_clk     (phy_rx_clk),
        .reset          (reset),
        .rx_byte        (rx_byte),
        .ctrl           (ctrl),
        .src_mac        (src_mac),
        .addr_match     (addr_match),
        .rx_data_out    (rx_data_out),
        .data_out_valid (data_out_valid),
        .frame_done     (frame_done),
        .frame_info     (frame_info)
    );

endmodule

`default_nettype wire

/* logic/payload_output.sv */
`default_nettype none

module payload_output
    import eth_mii_pkg::*, eth_frame_pkg::*;
(
    input  wire logic       phy_rx_clk,
    input  wire logic       reset,
    input  rx_byte_t        rx_byte,
    input  rx_ctrl_t        ctrl,
    input  mac_addr_t       src_mac,
    input  wire logic       addr_match,
    output logic [7:0]      rx_data_out,
    output logic            data_out_valid,
    output logic            frame_done,
    output frame_info_t     frame_info
);

    payload_len_t len_count;

    ////////////////////
    // Byte output
    ////////////////////

    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
        begin
            rx_data_out    <= 8'd0;
            data_out_valid <= 1'b0;
        end
        else
        begin
            data_out_valid <= ctrl.payload_byte && addr_match;
            if (ctrl.payload_byte && addr_match)
                rx_data_out <= rx_byte.data;
        end
    end

    ////////////////////
    // Length and summary
    ////////////////////

    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
        begin
            len_count  <= '0;
            frame_done <= 1'b0;
            frame_info <= '0;
        end
        else
        begin
            frame_done <= ctrl.frame_end;
            if (ctrl.frame_start)
                len_count <= '0;
            else if (ctrl.payload_byte && len_count != '1)
                len_count <= payload_len_t'(len_count + 11'd1);
            // Counted bytes include the FCS
            if (ctrl.frame_end)
                frame_info <= '{src_mac: src_mac, payload_len: len_count,
                                addr_match: addr_match};
        end
    end

endmodule

`default_nettype wire

/* logic/header_capture.sv */
`default_nettype none

module header_capture
    import eth_mii_pkg::*, eth_frame_pkg::*;
(
    input  wire logic phy_rx_clk,
    input  wire logic reset,
    input  rx_byte_t  rx_byte,
    input  rx_ctrl_t  ctrl,
    output mac_addr_t src_mac,
    output logic      addr_match
);

    mac_addr_t dest_mac;

    ////////////////////
    // Address shift registers
    ////////////////////

    // Most significant byte arrives first
    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
        begin
            dest_mac <= '0;
            src_mac  <= '0;
        end
        else if (ctrl.frame_start)
        begin
            dest_mac <= '0;
            src_mac  <= '0;
        end
        else
        begin
            if (ctrl.dest_shift)
                dest_mac <= {dest_mac[39:0], rx_byte.data};
            if (ctrl.src_shift)
                src_mac <= {src_mac[39:0], rx_byte.data};
        end
    end

    // Destination filter, valid one edge after the last dest byte
    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
            addr_match <= 1'b0;
        else if (ctrl.frame_start)
            addr_match <= 1'b0;
        else
            addr_match <= (dest_mac == BOARD_MAC);
    end

endmodule

`default_nettype wire

/* logic/frame_rx_ctrl.sv */
`default_nettype none

module frame_rx_ctrl
    import eth_mii_pkg::*, eth_frame_pkg::*;
(
    input  wire logic phy_rx_clk,
    input  wire logic reset,
    input  rx_byte_t  rx_byte,
    output rx_ctrl_t  ctrl,
    output rx_state_e status
);

    rx_state_e  state;
    rx_state_e  state_next;
    logic [2:0] byte_count;
    logic [2:0] count_next;
    logic [2:0] count_inc;

    assign count_inc = 3'(byte_count + 3'd1);
    assign status    = state;

    ////////////////////
    // State register
    ////////////////////

    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= IDLE;
            byte_count <= 3'd0;
        end
        else
        begin
            state      <= state_next;
            byte_count <= count_next;
        end
    end

    ////////////////////
    // Next state and commands
    ////////////////////

    always_comb
    begin
        state_next = state;
        count_next = byte_count;
        ctrl       = '0;
        case (state)
            IDLE:
            begin
                if (rx_byte.strobe && rx_byte.data == PREAMBLE_BYTE)
                begin
                    state_next = PREAMBLE;
                    count_next = 3'd1;
                end
            end
            PREAMBLE:
            begin
                if (!rx_byte.active)
                    state_next = IDLE;
                else if (rx_byte.strobe)
                begin
                    if (rx_byte.data != PREAMBLE_BYTE)
                        state_next = IDLE;
                    else if (count_inc == PREAMBLE_COUNT)
                        state_next = SFD;
                    count_next = count_inc;
                end
            end
            SFD:
            begin
                if (!rx_byte.active)
                    state_next = IDLE;
                else if (rx_byte.strobe)
                begin
                    if (rx_byte.data == SFD_BYTE)
                    begin
                        ctrl.frame_start = 1'b1;
                        state_next       = DEST_MAC;
                        count_next       = 3'd0;
                    end
                    else
                        state_next = IDLE;
                end
            end
            DEST_MAC, SRC_MAC:
            begin
                if (!rx_byte.active)
                    state_next = IDLE;
                else if (rx_byte.strobe)
                begin
                    ctrl.dest_shift = (state == DEST_MAC);
                    ctrl.src_shift  = (state == SRC_MAC);
                    count_next      = count_inc;
                    if (count_inc == MAC_ADDR_BYTES)
                    begin
                        // Address field done
                        state_next = (state == DEST_MAC) ? SRC_MAC : PAYLOAD;
                        count_next = 3'd0;
                    end
                end
            end
            PAYLOAD:
            begin
                if (!rx_byte.active)
                    state_next = FINISH;
                else if (rx_byte.strobe)
                    ctrl.payload_byte = 1'b1;
            end
            FINISH:
            begin
                ctrl.frame_end = 1'b1;
                state_next     = IDLE;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/nibble_assembler.sv */
`default_nettype none

module nibble_assembler
    import eth_mii_pkg::*;
(
    input  wire logic       phy_rx_clk,
    input  wire logic       reset,
    input  wire logic [3:0] phy_rxd,
    input  wire logic       phy_rx_ctrl,
    output rx_byte_t        rx_byte
);

    logic       phase;
    logic [3:0] low_nibble;

    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
        begin
            phase      <= 1'b0;
            low_nibble <= 4'd0;
            rx_byte    <= '0;
        end
        else
        begin
            rx_byte.active <= phy_rx_ctrl;
            rx_byte.strobe <= 1'b0;
            if (phy_rx_ctrl)
            begin
                phase <= ~phase;
                if (!phase)
                begin
                    low_nibble <= phy_rxd;
                end
                else
                begin
                    // High nibble completes the byte
                    rx_byte.data   <= {phy_rxd, low_nibble};
                    rx_byte.strobe <= 1'b1;
                end
            end
            else
            begin
                // Realign on every gap in the control level
                phase <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/eth_frame_pkg.sv */
`default_nettype none

package eth_frame_pkg;

    ////////////////////
    // Addresses
    ////////////////////

    typedef logic [47:0] mac_addr_t;

    localparam logic [2:0] MAC_ADDR_BYTES = 3'd6;

    // Address this board answers to
    localparam mac_addr_t BOARD_MAC = 48'h30_9C_23_1E_EC_21;

    // Saturates at 2047
    typedef logic [10:0] payload_len_t;

    ////////////////////
    // Receiver control
    ////////////////////

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        DEST_MAC,
        SRC_MAC,
        PAYLOAD,
        FINISH
    } rx_state_e;

    // Commands from the FSM to the datapath
    typedef struct packed {
        logic dest_shift;
        logic src_shift;
        logic payload_byte;
        logic frame_start;
        logic frame_end;
    } rx_ctrl_t;

    // Per-frame summary
    typedef struct packed {
        mac_addr_t    src_mac;
        payload_len_t payload_len;
        logic         addr_match;
    } frame_info_t;

endpackage

`default_nettype wire

/* logic/eth_mii_pkg.sv */
`default_nettype none

package eth_mii_pkg;

    ////////////////////
    // Byte stream from the PHY side
    ////////////////////

    // One assembled byte, strobe is a single-cycle pulse
    typedef struct packed {
        logic [7:0] data;
        logic       strobe;
        logic       active;
    } rx_byte_t;

    ////////////////////
    // Preamble and start delimiter
    ////////////////////

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    // Bytes of 0x55 expected ahead of the delimiter
    localparam logic [2:0] PREAMBLE_COUNT = 3'd7;

endpackage

`default_nettype wire
